// File: design/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_LREGS  = 32;
    localparam int ROB_DEPTH  = 8;
    localparam int MUL_STAGES = 3;

    // rv32 major opcodes
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD = 3'b000; // also sub, mul
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;
    localparam logic [6:0] F7_MUL  = 7'b0000001;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [31:0]                  inst_t;
    typedef logic [$clog2(NUM_LREGS)-1:0] lreg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [$clog2(ROB_DEPTH):0]   rob_cnt_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        ROB_FREE   = 2'd0,
        ROB_ISSUED = 2'd1,
        ROB_DONE   = 2'd2
    } rob_state_e;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        alu_op_e  op;
        word_t    a;
        word_t    b;
    } issue_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } result_t;

    typedef struct packed {
        logic  valid;
        lreg_t rd;
        word_t value;
    } commit_t;

endpackage

`default_nettype wire

// File: design/dispatch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl import ooo_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       in_valid,
    output logic      in_ready,
    input  inst_t     in_inst,
    output lreg_t     rs1,
    output lreg_t     rs2,
    input  wire       rs1_busy,
    input  wire       rs2_busy,
    input  rob_tag_t  rs1_tag,
    input  rob_tag_t  rs2_tag,
    input  word_t     reg_a,
    input  word_t     reg_b,
    input  word_t     rob_a,
    input  word_t     rob_b,
    input  wire       rob_a_done,
    input  wire       rob_b_done,
    input  wire       rob_full,
    input  rob_tag_t  rob_tail,
    output logic      alloc,
    output lreg_t     alloc_rd,
    output issue_t    alu_issue,
    output issue_t    mul_issue
);

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm;
    logic       legal;
    logic       is_mul;
    logic       use_imm;
    alu_op_e    op;
    logic       a_wait;
    logic       b_wait;
    logic       a_young;
    logic       b_young;
    logic       fire;
    word_t      opnd_a;
    word_t      opnd_b;
    rob_tag_t   last_tag;
    logic       last_alloc;

    assign opcode = in_inst[6:0];
    assign f3     = in_inst[14:12];
    assign f7     = in_inst[31:25];
    assign imm    = {{20{in_inst[31]}}, in_inst[31:20]};
    assign rs1    = in_inst[19:15];
    assign rs2    = in_inst[24:20];

    always_comb begin
        legal   = 1'b0;
        is_mul  = 1'b0;
        use_imm = 1'b0;
        op      = ALU_ADD;
        if (opcode == OP_REG) begin
            if (f7 == F7_MUL && f3 == F3_ADD) begin
                legal  = 1'b1;
                is_mul = 1'b1;
            end else if (f7 == F7_SUB && f3 == F3_ADD) begin
                legal = 1'b1;
                op    = ALU_SUB;
            end else if (f7 == F7_BASE) begin
                legal = 1'b1;
                case (f3)
                    F3_ADD:  op = ALU_ADD;
                    F3_SLT:  op = ALU_SLT;
                    F3_XOR:  op = ALU_XOR;
                    F3_OR:   op = ALU_OR;
                    F3_AND:  op = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
        end else if (opcode == OP_IMM) begin
            legal   = 1'b1;
            use_imm = 1'b1;
            case (f3)
                F3_ADD:  op = ALU_ADD;
                F3_XOR:  op = ALU_XOR;
                F3_OR:   op = ALU_OR;
                F3_AND:  op = ALU_AND;
                default: legal = 1'b0; // no slti in this core
            endcase
        end
    end

    // producer allocated last cycle cannot have written back yet
    always_ff @(posedge clk) begin
        last_tag <= rob_tail;
        if (rst) begin
            last_alloc <= 1'b0;
        end else begin
            last_alloc <= fire;
        end
    end

    assign a_young = last_alloc && (rs1_tag == last_tag);
    assign b_young = last_alloc && (rs2_tag == last_tag);

    assign a_wait = legal && rs1_busy && (a_young || !rob_a_done);
    assign b_wait = legal && !use_imm && rs2_busy && (b_young || !rob_b_done);

    assign in_ready = !rob_full && !a_wait && !b_wait;
    assign fire     = in_valid && in_ready;

    always_comb begin
        opnd_a = '0;
        opnd_b = '0;
        if (legal) begin
            opnd_a = rs1_busy ? rob_a : reg_a;
            if (use_imm) begin
                opnd_b = imm;
            end else begin
                opnd_b = rs2_busy ? rob_b : reg_b;
            end
        end
    end

    assign alloc    = fire;
    assign alloc_rd = legal ? in_inst[11:7] : '0; // junk commits to x0

    always_comb begin
        alu_issue.valid = fire && !is_mul;
        alu_issue.tag   = rob_tail;
        alu_issue.op    = op;
        alu_issue.a     = opnd_a;
        alu_issue.b     = opnd_b;
        mul_issue.valid = fire && is_mul;
        mul_issue.tag   = rob_tail;
        mul_issue.op    = ALU_ADD; // unused by the multiplier
        mul_issue.a     = opnd_a;
        mul_issue.b     = opnd_b;
    end

endmodule

`default_nettype wire

// File: design/rename_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_table import ooo_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  lreg_t    rs1,
    input  lreg_t    rs2,
    output logic     rs1_busy,
    output logic     rs2_busy,
    output rob_tag_t rs1_tag,
    output rob_tag_t rs2_tag,
    input  wire      alloc,
    input  lreg_t    alloc_rd,
    input  rob_tag_t alloc_tag,
    input  commit_t  commit,
    input  rob_tag_t commit_tag
);

    logic [NUM_LREGS-1:0] busy;
    rob_tag_t             tag_q [NUM_LREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            // only the latest producer clears the flag
            if (commit.valid && tag_q[commit.rd] == commit_tag) begin
                busy[commit.rd] <= 1'b0;
            end
            if (alloc && alloc_rd != '0) begin
                busy[alloc_rd] <= 1'b1; // rename write wins over the clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_q[alloc_rd] <= alloc_tag;
        end
    end

    assign rs1_busy = busy[rs1];
    assign rs2_busy = busy[rs2];
    assign rs1_tag  = tag_q[rs1];
    assign rs2_tag  = tag_q[rs2];

endmodule

`default_nettype wire

// File: design/arch_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module arch_regfile import ooo_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  lreg_t   rs1,
    input  lreg_t   rs2,
    output word_t   reg_a,
    output word_t   reg_b,
    input  commit_t commit
);

    word_t regs [NUM_LREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_LREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.value;
        end
    end

    assign reg_a = (rs1 == '0) ? '0 : regs[rs1];
    assign reg_b = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: design/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit import ooo_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  issue_t  issue,
    output result_t result
);

    word_t value;

    always_comb begin
        case (issue.op)
            ALU_ADD: value = issue.a + issue.b;
            ALU_SUB: value = issue.a - issue.b;
            ALU_AND: value = issue.a & issue.b;
            ALU_OR:  value = issue.a | issue.b;
            ALU_XOR: value = issue.a ^ issue.b;
            ALU_SLT: value = {{(XLEN-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
            default: value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        result.tag   <= issue.tag;
        result.value <= value;
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid;
        end
    end

endmodule

`default_nettype wire

// File: design/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit import ooo_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  issue_t  issue,
    output result_t result
);

    logic [MUL_STAGES-1:0] vld;
    rob_tag_t              tag_q  [MUL_STAGES];
    word_t                 prod_q [MUL_STAGES];

    // low half only, later stages give retiming room
    always_ff @(posedge clk) begin
        prod_q[0] <= issue.a * issue.b;
        tag_q[0]  <= issue.tag;
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
            tag_q[i]  <= tag_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[MUL_STAGES-2:0], issue.valid};
        end
    end

    always_comb begin
        result.valid = vld[MUL_STAGES-1];
        result.tag   = tag_q[MUL_STAGES-1];
        result.value = prod_q[MUL_STAGES-1];
    end

endmodule

`default_nettype wire

// File: design/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  wire      alloc,
    input  lreg_t    alloc_rd,
    output rob_tag_t rob_tail,
    output logic     rob_full,
    input  result_t  alu_result,
    input  result_t  mul_result,
    input  rob_tag_t rs1_tag,
    input  rob_tag_t rs2_tag,
    output word_t    rob_a,
    output word_t    rob_b,
    output logic     rob_a_done,
    output logic     rob_b_done,
    output commit_t  commit,
    output rob_tag_t commit_tag
);

    rob_state_e state [ROB_DEPTH];
    lreg_t      rd_q  [ROB_DEPTH];
    word_t      val_q [ROB_DEPTH];
    rob_tag_t   head;
    rob_tag_t   tail;
    rob_cnt_t   count;
    logic       do_commit;

    assign do_commit = (state[head] == ROB_DONE);
    assign rob_full  = (count == rob_cnt_t'(ROB_DEPTH));
    assign rob_tail  = tail;

    // operand lookup for dispatch
    assign rob_a      = val_q[rs1_tag];
    assign rob_b      = val_q[rs2_tag];
    assign rob_a_done = (state[rs1_tag] == ROB_DONE);
    assign rob_b_done = (state[rs2_tag] == ROB_DONE);

    always_comb begin
        commit.valid = do_commit;
        commit.rd    = rd_q[head];
        commit.value = val_q[head];
    end
    assign commit_tag = head;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state[i] <= ROB_FREE;
            end
        end else begin
            if (alu_result.valid) state[alu_result.tag] <= ROB_DONE;
            if (mul_result.valid) state[mul_result.tag] <= ROB_DONE;
            if (do_commit) begin
                state[head] <= ROB_FREE;
                head        <= head + 1'b1;
            end
            if (alloc) begin
                state[tail] <= ROB_ISSUED;
                tail        <= tail + 1'b1; // wraps, depth is a power of two
            end
            case ({alloc, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) rd_q[tail] <= alloc_rd;
        if (alu_result.valid) val_q[alu_result.tag] <= alu_result.value;
        if (mul_result.valid) val_q[mul_result.tag] <= mul_result.value;
    end

endmodule

`default_nettype wire

// File: design/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  wire     in_valid,
    output logic    in_ready,
    input  inst_t   in_inst,
    output commit_t commit
);

    lreg_t    rs1, rs2;
    logic     rs1_busy, rs2_busy;
    rob_tag_t rs1_tag, rs2_tag;
    word_t    reg_a, reg_b;
    word_t    rob_a, rob_b;
    logic     rob_a_done, rob_b_done;
    logic     rob_full;
    rob_tag_t rob_tail;
    logic     alloc;
    lreg_t    alloc_rd;
    issue_t   alu_issue, mul_issue;
    result_t  alu_result, mul_result;
    rob_tag_t commit_tag;

    dispatch_ctrl u_dispatch (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_inst(in_inst),
        .rs1(rs1), .rs2(rs2),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .reg_a(reg_a), .reg_b(reg_b),
        .rob_a(rob_a), .rob_b(rob_b),
        .rob_a_done(rob_a_done), .rob_b_done(rob_b_done),
        .rob_full(rob_full), .rob_tail(rob_tail),
        .alloc(alloc), .alloc_rd(alloc_rd),
        .alu_issue(alu_issue), .mul_issue(mul_issue)
    );

    rename_table u_rename (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .alloc(alloc), .alloc_rd(alloc_rd), .alloc_tag(rob_tail),
        .commit(commit), .commit_tag(commit_tag)
    );

    arch_regfile u_regfile (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2),
        .reg_a(reg_a), .reg_b(reg_b),
        .commit(commit)
    );

    alu_unit u_alu (.clk(clk), .rst(rst), .issue(alu_issue), .result(alu_result));

    mul_unit u_mul (.clk(clk), .rst(rst), .issue(mul_issue), .result(mul_result));

    reorder_buffer u_rob (
        .clk(clk), .rst(rst),
        .alloc(alloc), .alloc_rd(alloc_rd),
        .rob_tail(rob_tail), .rob_full(rob_full),
        .alu_result(alu_result), .mul_result(mul_result),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .rob_a(rob_a), .rob_b(rob_b),
        .rob_a_done(rob_a_done), .rob_b_done(rob_b_done),
        .commit(commit), .commit_tag(commit_tag)
    );

endmodule

`default_nettype wire

// File: tests/ooo_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_chk import ooo_pkg::*; (
    input wire        clk,
    input wire        rst,
    input rob_cnt_t   count,
    input commit_t    commit,
    input result_t    alu_result,
    input result_t    mul_result,
    input rob_state_e alu_state,
    input rob_state_e mul_state
);

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count <= rob_cnt_t'(ROB_DEPTH))
        else $error("reorder buffer count above its depth");

    // head state must agree with the occupancy count
    commit_from_live: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> count != '0)
        else $error("commit from an empty reorder buffer");

    // write-back only into an allocated slot
    alu_wb_live: assert property (@(posedge clk) disable iff (rst)
        alu_result.valid |-> alu_state != ROB_FREE)
        else $error("ALU write-back into a free entry");

    mul_wb_live: assert property (@(posedge clk) disable iff (rst)
        mul_result.valid |-> mul_state != ROB_FREE)
        else $error("multiplier write-back into a free entry");

endmodule

bind reorder_buffer ooo_core_chk u_chk (
    .clk(clk), .rst(rst),
    .count(count), .commit(commit),
    .alu_result(alu_result), .mul_result(mul_result),
    .alu_state(state[alu_result.tag]), .mul_state(state[mul_result.tag])
);

`default_nettype wire

// File: tests/ooo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 3000;

    logic    clk;
    logic    rst;
    logic    in_valid;
    logic    in_ready;
    inst_t   in_inst;
    commit_t commit_out;

    word_t   model_regs [NUM_LREGS];
    commit_t exp_q [$];
    int      cycles;
    int      stall_cycles;

    ooo_core uut (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_inst(in_inst),
        .commit(commit_out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d commits still pending",
                     cycles, exp_q.size());
            abort_run();
        end
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic inst_t rtype(input logic [6:0] f7, input lreg_t rs2, input lreg_t rs1,
                                    input logic [2:0] f3, input lreg_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic inst_t itype(input logic [11:0] imm, input lreg_t rs1,
                                    input logic [2:0] f3, input lreg_t rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic lreg_t pick_src();
        return lreg_t'(1 + $urandom % 8); // x1..x8 hold the constants
    endfunction

    function automatic logic [11:0] rand_imm();
        logic [31:0] r;
        r = $urandom;
        return r[11:0];
    endfunction

    // rv32 semantics, unsupported words retire as x0 = 0
    function automatic commit_t predict(input inst_t inst);
        commit_t c;
        word_t   a;
        word_t   b;
        word_t   imm;
        logic    ok;
        a       = model_regs[inst[19:15]];
        b       = model_regs[inst[24:20]];
        imm     = {{20{inst[31]}}, inst[31:20]};
        ok      = 1'b1;
        c.valid = 1'b1;
        c.rd    = inst[11:7];
        c.value = '0;
        if (inst[6:0] == OP_REG) begin
            case ({inst[31:25], inst[14:12]})
                {F7_BASE, F3_ADD}: c.value = a + b;
                {F7_SUB, F3_ADD}:  c.value = a - b;
                {F7_BASE, F3_AND}: c.value = a & b;
                {F7_BASE, F3_OR}:  c.value = a | b;
                {F7_BASE, F3_XOR}: c.value = a ^ b;
                {F7_BASE, F3_SLT}: c.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                {F7_MUL, F3_ADD}:  c.value = a * b;
                default:           ok = 1'b0;
            endcase
        end else if (inst[6:0] == OP_IMM) begin
            case (inst[14:12])
                F3_ADD:  c.value = a + imm;
                F3_AND:  c.value = a & imm;
                F3_OR:   c.value = a | imm;
                F3_XOR:  c.value = a ^ imm;
                default: ok = 1'b0;
            endcase
        end else begin
            ok = 1'b0;
        end
        if (!ok) begin
            c.rd    = '0;
            c.value = '0;
        end
        return c;
    endfunction

    // accepted on the posedge after the negedge that sees in_ready
    task automatic send(input inst_t inst);
        commit_t exp;
        @(posedge clk);
        in_valid <= 1'b1;
        in_inst  <= inst;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        exp = predict(inst);
        exp_q.push_back(exp);
        if (exp.rd != '0) model_regs[exp.rd] = exp.value;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic watch_commits();
        commit_t exp;
        forever begin
            @(negedge clk);
            if (in_valid && !in_ready) stall_cycles++;
            if (!rst && commit_out.valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("Commit to x%0d at %0t with no instruction outstanding",
                             commit_out.rd, $time);
                    abort_run();
                end
                exp = exp_q.pop_front();
                assert (commit_out.rd == exp.rd && commit_out.value == exp.value) else begin
                    $display("Mismatch at %0t: commit x%0d = %h, expected x%0d = %h", $time,
                             commit_out.rd, commit_out.value, exp.rd, exp.value);
                    abort_run();
                end
            end
        end
    endtask

    task automatic reset_idle();
        @(negedge clk);
        assert (in_ready) else begin
            $display("in_ready is low right after reset");
            abort_run();
        end
        repeat (10) begin
            @(negedge clk);
            assert (!commit_out.valid) else begin
                $display("Commit seen at %0t without any input", $time);
                abort_run();
            end
        end
    endtask

    task automatic alu_ops();
        logic [6:0] r_f7 [6];
        logic [2:0] r_f3 [6];
        logic [2:0] i_f3 [4];
        r_f7 = '{F7_BASE, F7_SUB, F7_BASE, F7_BASE, F7_BASE, F7_BASE};
        r_f3 = '{F3_ADD, F3_ADD, F3_AND, F3_OR, F3_XOR, F3_SLT};
        i_f3 = '{F3_ADD, F3_AND, F3_OR, F3_XOR};
        for (int i = 1; i <= 8; i++) begin
            send(itype(rand_imm(), 5'd0, F3_ADD, lreg_t'(i)));
        end
        for (int k = 0; k < 12; k++) begin
            send(rtype(r_f7[k % 6], pick_src(), pick_src(), r_f3[k % 6], lreg_t'(9 + k % 6)));
        end
        for (int k = 0; k < 8; k++) begin
            send(itype(rand_imm(), pick_src(), i_f3[k % 4], lreg_t'(9 + k % 6)));
        end
        drain();
    endtask

    task automatic dep_chain();
        lreg_t prev;
        lreg_t rd;
        send(itype(rand_imm(), pick_src(), F3_ADD, 5'd10));
        prev = 5'd10;
        for (int k = 0; k < 12; k++) begin
            rd = lreg_t'(10 + k % 3);
            if (k % 4 == 3) begin
                send(itype(rand_imm(), prev, F3_XOR, rd));
            end else begin
                send(rtype(k % 2 ? F7_SUB : F7_BASE, pick_src(), prev, F3_ADD, rd));
            end
            prev = rd;
        end
        drain();
    endtask

    task automatic mul_order();
        send(rtype(F7_MUL, pick_src(), pick_src(), F3_ADD, 5'd20));
        for (int k = 0; k < 4; k++) begin
            send(rtype(F7_BASE, pick_src(), pick_src(), F3_ADD, lreg_t'(21 + k)));
        end
        drain();
    endtask

    task automatic mul_burst();
        int    stalls_before;
        lreg_t prev;
        lreg_t rd;
        stalls_before = stall_cycles;
        prev = pick_src();
        for (int k = 0; k < 12; k++) begin
            rd = lreg_t'(16 + k % 8);
            send(rtype(F7_MUL, pick_src(), prev, F3_ADD, rd)); // reads last product
            prev = rd;
            idle($urandom % 3);
        end
        drain();
        assert (stall_cycles > stalls_before) else begin
            $display("in_ready never went low during the multiplier burst");
            abort_run();
        end
    endtask

    task automatic zero_reg();
        send(itype(rand_imm(), pick_src(), F3_ADD, 5'd0));
        send(rtype(F7_BASE, pick_src(), pick_src(), F3_ADD, 5'd0));
        send(32'h0000_2383);                                        // lw
        send(rtype(F7_BASE, pick_src(), pick_src(), 3'b001, 5'd7)); // sll
        send(itype(rand_imm(), pick_src(), 3'b010, 5'd6));          // slti
        send(rtype(F7_MUL, pick_src(), pick_src(), 3'b001, 5'd5));  // mulh
        send(rtype(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd25));
        send(itype(rand_imm(), 5'd0, F3_OR, 5'd26));
        drain();
    endtask

    initial begin
        void'($urandom(32'h78c0_6de3));
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_inst      = '0;
        cycles       = 0;
        stall_cycles = 0;
        for (int i = 0; i < NUM_LREGS; i++) begin
            model_regs[i] = '0;
        end
        fork
            watch_commits();
        join_none
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        reset_idle();
        alu_ops();
        dep_chain();
        mul_order();
        mul_burst();
        zero_reg();
        idle(4);

        if (exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d expected commits never arrived", exp_q.size());
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: ooo_core.f
design/ooo_pkg.sv
design/dispatch_ctrl.sv
design/rename_table.sv
design/arch_regfile.sv
design/alu_unit.sv
design/mul_unit.sv
design/reorder_buffer.sv
design/ooo_core.sv
tests/ooo_core_chk.sv
tests/ooo_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= ooo_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
